// File: Makefile
TOP = dcache_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/backing_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_consts.svh"

module backing_mem (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ar_start,
	input  logic [31:0]            ar_addr,
	input  mem_pkg::mem_wr_t       wr,
	output mem_pkg::mem_rd_beat_t  beat
);
	localparam int WORD_W = $clog2(`MEM_WORDS);
	localparam int BEAT_W = $clog2(`DC_BEATS);
	localparam int LINE_W = WORD_W - BEAT_W;
	localparam logic [BEAT_W:0] SEQ_END = (BEAT_W+1)'(`DC_BEATS);

	logic [31:0]        mem [`MEM_WORDS] = '{default: '0};
	logic [31:0]        rd_off;
	logic [31:0]        wr_off;
	logic [WORD_W-1:0]  wr_word;
	logic [LINE_W-1:0]  line_q;
	// 0 when idle, otherwise beat number plus one
	logic [BEAT_W:0]    seq;
	logic [BEAT_W-1:0]  beat_no;
	logic               streaming;
	logic [31:0]        rdata_q;
	logic               rvalid_q;
	logic               rlast_q;

	assign rd_off    = ar_addr - `MEM_BASE;
	assign wr_off    = wr.waddr - `MEM_BASE;
	assign wr_word   = {wr_off[WORD_W+1:3], 1'b0};
	assign beat_no   = seq[BEAT_W-1:0] - 1'b1;
	assign streaming = (seq != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			seq      <= '0;
			rvalid_q <= 1'b0;
			rlast_q  <= 1'b0;
		end else begin
			rvalid_q <= streaming;
			rlast_q  <= (seq == SEQ_END);
			if (ar_start) begin
				seq <= 1;
			end else if (seq == SEQ_END) begin
				seq <= '0;
			end else if (streaming) begin
				seq <= seq + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_start) begin
			line_q <= rd_off[WORD_W+1:BEAT_W+2];
		end
		rdata_q <= mem[{line_q, beat_no}];
		// low four bytes to the even word, high four to the odd one
		if (wr.wen) begin
			for (int b = 0; b < 8; b++) begin
				if (wr.wmask[b]) begin
					mem[wr_word + WORD_W'(b / 4)][8*(b%4) +: 8] <= wr.wdata[8*b +: 8];
				end
			end
		end
	end

	assign beat.rdata  = rdata_q;
	assign beat.rvalid = rvalid_q;
	assign beat.rlast  = rlast_q;

	a_ar_when_idle: assert property (@(posedge clk) disable iff (rst)
		ar_start |-> !streaming);

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
`default_nettype none

`include "dcache_consts.svh"

package cache_pkg;

	// one access from the core
	typedef struct packed {
		logic [31:0] addr;
		logic [63:0] wdata;
		// one bit per byte of wdata
		logic [7:0]  wmask;
		logic        wren;
	} cpu_req_t;

	// one bit per way, used for hit, victim and fill
	typedef logic [`DC_WAYS-1:0] way_vec_t;

	// quarter line, four 32-bit lanes
	typedef logic [127:0] ram_entry_t;

	typedef enum logic [1:0] {
		IDLE,
		REFILL,
		RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: design/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_pkg::cpu_req_t    req,
	input  logic                   valid,
	input  cache_pkg::way_vec_t    hit,
	input  mem_pkg::mem_rd_beat_t  beat,
	output logic                   ready,
	output logic                   ar_start,
	output logic                   refilling,
	output logic                   mem_wen,
	output logic                   lookup_en,
	output cache_pkg::way_vec_t    hit_q
);
	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic        write_req;
	logic        read_hit;
	logic        read_miss;
	logic        beat_last;

	// requests are only looked at in IDLE
	assign lookup_en = (state == IDLE) && valid;
	assign write_req = lookup_en && req.wren;
	assign read_hit  = lookup_en && !req.wren && (hit != '0);
	assign read_miss = lookup_en && !req.wren && (hit == '0);
	assign beat_last = beat.rvalid && beat.rlast;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (write_req || read_hit) begin
					state_nxt = RESPOND;
				end else if (read_miss) begin
					state_nxt = REFILL;
				end
			end
			// retried lookup in IDLE then hits
			REFILL: begin
				if (beat_last) begin
					state_nxt = IDLE;
				end
			end
			RESPOND: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			hit_q <= '0;
		end else begin
			state <= state_nxt;
			// hit way steers the output mux in RESPOND
			if (read_hit) begin
				hit_q <= hit;
			end
		end
	end

	assign ready     = (state == RESPOND);
	assign ar_start  = read_miss;
	assign refilling = (state == REFILL);
	assign mem_wen   = write_req;

	// the memory must not finish a burst we did not ask for
	a_rlast_in_refill: assert property (@(posedge clk) disable iff (rst)
		beat_last |-> (state == REFILL));

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 valid,
	input  cache_pkg::cpu_req_t  req,
	output logic                 ready,
	output logic [63:0]          dout
);
	import cache_pkg::*;
	import mem_pkg::*;

	way_vec_t      hit;
	way_vec_t      hit_q;
	way_vec_t      victim;
	mem_rd_beat_t  beat;
	mem_wr_t       wr;
	ram_entry_t    ram_wdata;
	ram_entry_t    ram_rdata [`DC_WAYS];
	ram_entry_t    line_sel;
	logic          ar_start;
	logic          refilling;
	logic          mem_wen;
	logic          lookup_en;
	logic          beat_fire;
	logic [3:0]    beat_idx;
	logic [3:0]    lane_sel;
	logic [5:0]    ram_addr;

	dcache_ctrl ctrl_i (
		.clk, .rst, .req, .valid, .hit, .beat,
		.ready, .ar_start, .refilling, .mem_wen, .lookup_en, .hit_q
	);

	// ctrl is idle when neither refilling nor responding
	refill_counter counter_i (
		.clk, .rst, .refilling, .advance(!refilling && !ready),
		.beat, .beat_idx, .victim
	);

	tag_array tags_i (
		.clk, .rst, .addr(req.addr),
		.fill(beat_fire && beat.rlast), .invalidate(mem_wen),
		.fill_way(victim), .hit
	);

	assign beat_fire = refilling && beat.rvalid;
	// refill walks the quarters of the set, lookup uses the request
	assign ram_addr  = refilling ? {req.addr[9:6], beat_idx[3:2]} : req.addr[9:4];
	assign lane_sel  = 4'b0001 << beat_idx[1:0];
	assign ram_wdata = {4{beat.rdata}};

	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
		line_ram #(.DEPTH(`DC_RAM_DEPTH)) way_ram (
			.clk,
			.en(lookup_en || (beat_fire && victim[w])),
			.lane_we((beat_fire && victim[w]) ? lane_sel : 4'b0000),
			.addr(ram_addr),
			.wdata(ram_wdata),
			.rdata(ram_rdata[w])
		);
	end

	always_comb begin
		line_sel = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (hit_q[w]) begin
				line_sel = ram_rdata[w];
			end
		end
	end

	assign dout = req.addr[3] ? line_sel[127:64] : line_sel[63:0];

	assign wr = '{waddr: req.addr, wdata: req.wdata, wmask: req.wmask, wen: mem_wen};

	backing_mem mem_i (
		.clk, .rst, .ar_start, .ar_addr({req.addr[31:6], 6'b0}), .wr, .beat
	);

	// every access must fall inside the memory window
	a_in_window: assert property (@(posedge clk) disable iff (rst)
		valid |-> ((req.addr - `MEM_BASE) < 32'(`MEM_WORDS * 4)));

endmodule

`default_nettype wire

// File: design/line_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_consts.svh"

module line_ram #(
	parameter int DEPTH = `DC_RAM_DEPTH
) (
	input  logic                   clk,
	input  logic                   en,
	input  logic [3:0]             lane_we,
	input  logic [5:0]             addr,
	input  cache_pkg::ram_entry_t  wdata,
	output cache_pkg::ram_entry_t  rdata
);
	import cache_pkg::*;

	ram_entry_t mem [DEPTH];

	// read returns the old entry when a lane is written in the same cycle
	always_ff @(posedge clk) begin
		if (en) begin
			for (int l = 0; l < 4; l++) begin
				if (lane_we[l]) begin
					mem[addr][32*l +: 32] <= wdata[32*l +: 32];
				end
			end
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// one beat of a read burst
	typedef struct packed {
		logic [31:0] rdata;
		logic        rvalid;
		// high on the final beat only
		logic        rlast;
	} mem_rd_beat_t;

	// single-cycle write, 64 bits under a byte mask
	typedef struct packed {
		logic [31:0] waddr;
		logic [63:0] wdata;
		logic [7:0]  wmask;
		logic        wen;
	} mem_wr_t;

endpackage

`default_nettype wire

// File: design/refill_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_consts.svh"

module refill_counter (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   refilling,
	input  logic                   advance,
	input  mem_pkg::mem_rd_beat_t  beat,
	output logic [3:0]             beat_idx,
	output cache_pkg::way_vec_t    victim
);
	localparam logic [3:0] LAST_BEAT = 4'(`DC_BEATS - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_idx <= '0;
		end else if (!refilling) begin
			beat_idx <= '0;
		end else if (beat.rvalid) begin
			beat_idx <= beat_idx + 4'd1;
		end
	end

	// rotates every idle cycle so the way picked depends on request timing
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= {{(`DC_WAYS-1){1'b0}}, 1'b1};
		end else if (advance) begin
			victim <= {victim[`DC_WAYS-2:0], victim[`DC_WAYS-1]};
		end
	end

	// memory burst length and our beat count must agree
	a_last_beat: assert property (@(posedge clk) disable iff (rst)
		(refilling && beat.rvalid && beat.rlast) |-> (beat_idx == LAST_BEAT));

endmodule

`default_nettype wire

// File: design/tag_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_consts.svh"

module tag_array (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [31:0]          addr,
	input  logic                 fill,
	input  logic                 invalidate,
	input  cache_pkg::way_vec_t  fill_way,
	output cache_pkg::way_vec_t  hit
);
	import cache_pkg::*;

	localparam int SET_W = $clog2(`DC_SETS);

	logic [`DC_TAG_W-1:0]             tags [`DC_WAYS][`DC_SETS];
	logic [`DC_WAYS-1:0][`DC_SETS-1:0] line_vld;
	logic [SET_W-1:0]                 set;
	logic [`DC_TAG_W-1:0]             tag;
	way_vec_t                         tag_eq;

	// set sits just above the 64-byte offset
	assign set = addr[6 +: SET_W];
	assign tag = addr[31 -: `DC_TAG_W];

	always_comb begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			tag_eq[w] = (tags[w][set] == tag);
			hit[w]    = line_vld[w][set] && tag_eq[w];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			line_vld <= '0;
		end else begin
			for (int w = 0; w < `DC_WAYS; w++) begin
				if (fill && fill_way[w]) begin
					line_vld[w][set] <= 1'b1;
				end else if (invalidate && tag_eq[w]) begin
					// stale copies dropped on write-through
					line_vld[w][set] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (fill && fill_way[w]) begin
				tags[w][set] <= tag;
			end
		end
	end

	// a line may live in one way only
	a_hit_onehot0: assert property (@(posedge clk) disable iff (rst)
		$onehot0(hit));

endmodule

`default_nettype wire

// File: include/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DC_WAYS       4
`define DC_SETS       16
`define DC_TAG_W      22
// 32-bit beats per 64-byte line
`define DC_BEATS      16
// quarter lines held by one way RAM
`define DC_RAM_DEPTH  64

// backing memory window, 16 KB
`define MEM_WORDS     4096
`define MEM_BASE      32'h8000_0000

`endif

// File: sim.f
+incdir+include
design/cache_pkg.sv
design/mem_pkg.sv
design/dcache_ctrl.sv
design/refill_counter.sv
design/tag_array.sv
design/line_ram.sv
design/backing_mem.sv
design/dcache_top.sv
tests/tb_clock.sv
tests/dcache_tb.sv

// File: tests/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb;
	import cache_pkg::*;

	localparam int RAND_N     = 200;
	localparam int READY_WAIT = 40;
	localparam int CLK_NS     = 8;
	localparam int DW_N       = `MEM_WORDS / 2;

	logic        clk;
	logic        rst;
	logic        valid;
	cpu_req_t    req;
	logic        ready;
	logic [63:0] dout;

	// one entry per line of the vector file
	int          v_test [$];
	logic        v_wr [$];
	logic [31:0] v_addr [$];
	logic [63:0] v_wdata [$];
	logic [7:0]  v_mask [$];
	logic [63:0] v_exp [$];

	// expected memory, one entry per 64-bit doubleword of the window
	logic [63:0] ref_mem [DW_N] = '{default: '0};
	integer      seed;
	int          n_vec;
	bit          loaded;
	bit          aborted;
	int          errors;
	int          checks;
	int          tests_done;

	tb_clock #(.PERIOD_NS(CLK_NS), .RST_CYCLES(2)) clock_i (.clk, .rst);

	dcache_top dcache_top_i (.clk, .rst, .valid, .req, .ready, .dout);

	task automatic load_vectors();
		int          fd;
		int          n;
		int          num;
		logic [7:0]  op;
		logic [31:0] a;
		logic [63:0] wd;
		logic [7:0]  m;
		logic [63:0] e;
		string       line;
		fd = $fopen("tests/dcache_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/dcache_vectors.txt");
			aborted = 1'b1;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// comment and blank lines do not give six fields
			n = $sscanf(line, "%d %c %h %h %h %h", num, op, a, wd, m, e);
			if (n == 6) begin
				v_test.push_back(num);
				v_wr.push_back(op == "W");
				v_addr.push_back(a);
				v_wdata.push_back(wd);
				v_mask.push_back(m);
				v_exp.push_back(e);
			end
		end
		$fclose(fd);
		if (v_addr.size() == 0) begin
			$display("the vector file holds no accesses");
			aborted = 1'b1;
		end
	endtask

	function automatic int dw_index(logic [31:0] addr);
		logic [31:0] off;
		off = addr - `MEM_BASE;
		return int'(off[31:3]);
	endfunction

	// bytes under the mask replace the old ones
	function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] wd,
			logic [7:0] m);
		logic [63:0] r;
		r = old;
		for (int b = 0; b < 8; b++) begin
			if (m[b]) begin
				r[8*b +: 8] = wd[8*b +: 8];
			end
		end
		return r;
	endfunction

	// drive one request and hold it until the ready pulse
	task automatic run_access(input int tnum, input logic wr, input logic [31:0] addr,
			input logic [63:0] wd, input logic [7:0] m, input logic [63:0] exp,
			inout int test_err);
		int          waited;
		bit          ok;
		logic [63:0] rd;
		req    = '{addr: addr, wdata: wd, wmask: m, wren: wr};
		valid  = 1'b1;
		waited = 0;
		ok     = 1'b0;
		rd     = '0;
		while (!ok && waited < READY_WAIT) begin
			@(posedge clk);
			#1;
			waited++;
			if (ready) begin
				ok = 1'b1;
				rd = dout;
			end
		end
		if (!ok) begin
			$display("test %0d: no ready from the DUT within %0d cycles for the access at %h",
				tnum, READY_WAIT, addr);
			aborted = 1'b1;
			test_err++;
			errors++;
		end else if (wr) begin
			ref_mem[dw_index(addr)] = merge_bytes(ref_mem[dw_index(addr)], wd, m);
		end else begin
			checks++;
			if (rd !== exp) begin
				$display("MISMATCH at %0t: test %0d read of %h gave %h, expected %h",
					$time, tnum, addr, rd, exp);
				test_err++;
				errors++;
			end
		end
	endtask

	function automatic void report_test(int tnum, int acc, int err);
		$display("test %0d finished: %0d accesses, %0d errors", tnum, acc, err);
		tests_done++;
	endfunction

	initial begin
		int          test_acc;
		int          test_err;
		int          r;
		logic [31:0] addr;
		valid    = 1'b0;
		req      = '0;
		seed     = 32'hf870;
		test_acc = 0;
		test_err = 0;
		load_vectors();
		n_vec  = v_addr.size();
		loaded = 1'b1;
		wait (!rst);
		@(posedge clk);
		#1;
		for (int i = 0; i < n_vec && !aborted; i++) begin
			run_access(v_test[i], v_wr[i], v_addr[i], v_wdata[i], v_mask[i], v_exp[i],
				test_err);
			test_acc++;
			// a test ends where the next line carries a new number
			if (aborted || i == n_vec - 1 || v_test[i+1] != v_test[i]) begin
				report_test(v_test[i], test_acc, test_err);
				test_acc = 0;
				test_err = 0;
			end
		end
		// random phase, 8 tags by 4 sets by 2 doublewords
		for (int i = 0; i < RAND_N && !aborted; i++) begin
			r    = $random(seed);
			addr = `MEM_BASE + {r[5:3], 10'h0} + {r[2:1], 6'h0} + {r[0], 3'h0};
			run_access(6, r[8], addr, {$random(seed), $random(seed)}, r[16:9],
				ref_mem[dw_index(addr)], test_err);
			test_acc++;
		end
		if (test_acc > 0) begin
			report_test(6, test_acc, test_err);
		end
		valid = 1'b0;
		$display("tests run: %0d, reads checked: %0d, errors: %0d", tests_done, checks, errors);
		if (errors == 0 && !aborted) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// each access gets the same allowance as the per-access ready wait
	initial begin
		wait (loaded);
		#((n_vec + RAND_N) * READY_WAIT * CLK_NS);
		$display("timeout: the run did not finish in the allowed time");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/dcache_vectors.txt
# columns: test op address wdata mask expected, values in hex
# op R reads and checks expected, op W writes wdata under mask (one bit per byte)
1 R 80000000 0000000000000000 00 0000000000000000
1 R 80003fc0 0000000000000000 00 0000000000000000
2 W 80000100 1122334455667788 0f 0000000000000000
2 R 80000100 0000000000000000 00 0000000055667788
2 W 80000108 1122334455667788 81 0000000000000000
2 R 80000108 0000000000000000 00 1100000000000088
3 W 80000148 aaaaaaaabbbbbbbb ff 0000000000000000
3 W 80000170 0123456789abcdef ff 0000000000000000
3 R 80000140 0000000000000000 00 0000000000000000
3 R 80000148 0000000000000000 00 aaaaaaaabbbbbbbb
3 R 80000158 0000000000000000 00 0000000000000000
3 R 80000160 0000000000000000 00 0000000000000000
3 R 80000170 0000000000000000 00 0123456789abcdef
3 R 80000178 0000000000000000 00 0000000000000000
4 W 80000148 cccccccc00000000 f0 0000000000000000
4 R 80000148 0000000000000000 00 ccccccccbbbbbbbb
5 W 80000080 1111111111111111 ff 0000000000000000
5 W 80000480 2222222222222222 ff 0000000000000000
5 W 80000880 3333333333333333 ff 0000000000000000
5 W 80000c80 4444444444444444 ff 0000000000000000
5 W 80001080 5555555555555555 ff 0000000000000000
5 W 80001480 6666666666666666 ff 0000000000000000
5 R 80000080 0000000000000000 00 1111111111111111
5 R 80000480 0000000000000000 00 2222222222222222
5 R 80000880 0000000000000000 00 3333333333333333
5 R 80000c80 0000000000000000 00 4444444444444444
5 R 80001080 0000000000000000 00 5555555555555555
5 R 80001480 0000000000000000 00 6666666666666666

// File: tests/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

`default_nettype wire
